// ==== hw/bank_regs.sv ====
`timescale 1ns/1ns

module bank_regs (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [zbus_pkg::addr_w-1:0] ebus_a,
    input  logic                        ebus_iorq_n,
    input  logic                        bus_write,
    input  logic [zbus_pkg::data_w-1:0] wrdata,
    input  logic                        regs_enable,    // Low hides $F0-$F3
    output logic [zbus_pkg::data_w-1:0] cur_bank,
    output logic                        bank_hit,
    output logic [zbus_pkg::data_w-1:0] bank_rddata
);

    import zbus_pkg::*;

    logic [data_w-1:0] bank_r [bank_count];    // $F0..$F3
    logic [1:0]        io_idx;                 // Register picked by the port number
    logic [1:0]        mem_idx;                // Register picked by the memory quarter
    logic              port_in_range;

    ////////////////////////////////////////////////////////////
    // Port decode
    ////////////////////////////////////////////////////////////
    assign io_idx  = ebus_a[1:0];
    assign mem_idx = ebus_a[15:14];

    assign port_in_range = (ebus_a[7:0] >= io_bank0) && (ebus_a[7:0] <= io_bank3);

    // The whole block disappears from I/O space once dis_regs is set
    assign bank_hit = !ebus_iorq_n && regs_enable && port_in_range;

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < bank_count; i++) begin
                bank_r[i] <= '0;                // Page 0, writable, no overlay
            end
        end else begin
            if (bank_hit && bus_write) begin
                bank_r[io_idx] <= wrdata;
            end
        end
    end

    // Readback, only used by the read mux when bank_hit is high
    assign bank_rddata = bank_r[io_idx];

    // Bank for the quarter currently on the address bus
    //   $0000-$3FFF -> $F0
    //   $4000-$7FFF -> $F1
    //   $8000-$BFFF -> $F2
    //   $C000-$FFFF -> $F3
    assign cur_bank = bank_r[mem_idx];

endmodule

// ==== hw/io_regs.sv ====
`timescale 1ns/1ns

module io_regs (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [zbus_pkg::addr_w-1:0] ebus_a,
    input  logic                        ebus_iorq_n,
    input  logic                        ebus_rd_n,
    input  logic                        bus_write,
    input  logic [zbus_pkg::data_w-1:0] wrdata,
    input  logic                        cassette_sync,
    input  logic                        printer_sync,
    input  logic [63:0]                 keys,           // Active low, 8 rows
    input  logic                        bank_hit,
    input  logic [zbus_pkg::data_w-1:0] bank_rddata,
    output logic                        regs_enable,
    output logic                        cassette_out,
    output logic                        printer_out,
    output logic                        cpm_remap,
    output logic                        turbo_mode,
    output logic [zbus_pkg::data_w-1:0] ebus_d_out,
    output logic                        ebus_d_oe
);

    import zbus_pkg::*;

    io_port_e          port;
    logic              sel_sysctrl;
    logic              sel_cassette;
    logic              sel_cpm;
    logic              sel_printer;
    logic              sel_keyboard;
    logic              io_hit;
    logic              dis_regs_r;
    logic              dis_psgs_r;      // Stored and readable only
    logic [data_w-1:0] sysctrl_rd;
    logic [data_w-1:0] kb_rd;
    logic [data_w-1:0] rddata;

    ////////////////////////////////////////////////////////////
    // Port decode
    ////////////////////////////////////////////////////////////
    assign port = io_port_e'(ebus_a[7:0]);

    // These stay reachable with dis_regs set, so $FB can undo it
    assign sel_sysctrl  = !ebus_iorq_n && (port == io_sysctrl);
    assign sel_cassette = !ebus_iorq_n && (port == io_cassette);
    assign sel_cpm      = !ebus_iorq_n && (port == io_cpm);
    assign sel_printer  = !ebus_iorq_n && (port == io_printer);
    assign sel_keyboard = !ebus_iorq_n && (port == io_keyboard);

    assign io_hit = bank_hit | sel_sysctrl | sel_cassette | sel_cpm |
                    sel_printer | sel_keyboard;

    ////////////////////////////////////////////////////////////
    // Write registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dis_regs_r   <= 1'b0;
            dis_psgs_r   <= 1'b0;
            turbo_mode   <= 1'b0;
            cassette_out <= 1'b0;
            cpm_remap    <= 1'b0;
            printer_out  <= 1'b0;
        end else if (bus_write) begin
            if (sel_sysctrl) begin
                dis_regs_r <= wrdata[sysctrl_dis_regs_bit];
                dis_psgs_r <= wrdata[sysctrl_dis_psgs_bit];
                turbo_mode <= wrdata[sysctrl_turbo_bit];
            end
            if (sel_cassette) cassette_out <= wrdata[0];
            if (sel_cpm)      cpm_remap    <= wrdata[0];
            if (sel_printer)  printer_out  <= wrdata[0];
        end
    end

    assign regs_enable = !dis_regs_r;

    ////////////////////////////////////////////////////////////
    // Read data
    ////////////////////////////////////////////////////////////
    always_comb begin
        sysctrl_rd = '0;
        sysctrl_rd[sysctrl_dis_regs_bit] = dis_regs_r;
        sysctrl_rd[sysctrl_dis_psgs_bit] = dis_psgs_r;
        sysctrl_rd[sysctrl_turbo_bit]    = turbo_mode;
    end

    // Keyboard matrix, row n is scanned while a[8+n] is low
    always_comb begin
        kb_rd = '1;
        for (int row = 0; row < 8; row++) begin
            if (!ebus_a[8+row]) begin
                kb_rd = kb_rd & keys[row*8 +: 8];
            end
        end
    end

    always_comb begin
        rddata = '0;
        if (bank_hit)     rddata = bank_rddata;
        if (sel_sysctrl)  rddata = sysctrl_rd;
        if (sel_cassette) rddata = {{(data_w-1){1'b0}}, !cassette_sync};
        if (sel_cpm)      rddata = '0;      // Remap bit is write only
        if (sel_printer)  rddata = {{(data_w-1){1'b0}}, printer_sync};
        if (sel_keyboard) rddata = kb_rd;
    end

    assign ebus_d_out = rddata;
    assign ebus_d_oe  = !ebus_rd_n && io_hit;

endmodule

// ==== hw/mem_decode.sv ====
`timescale 1ns/1ns

module mem_decode (
    input  logic [zbus_pkg::addr_w-1:0] ebus_a,
    input  logic                        ebus_mreq_n,
    input  logic                        ebus_wr_n,
    input  logic [zbus_pkg::data_w-1:0] cur_bank,
    output logic [zbus_pkg::ba_w-1:0]   ebus_ba,
    output logic                        ebus_ram_ce_n,  // 512 KB RAM
    output logic                        ebus_cart_ce_n,
    output logic                        ebus_ram_we_n
);

    import zbus_pkg::*;

    logic [page_w-1:0] page;
    logic              bank_ro;
    logic              bank_overlay;
    logic              sel_sysram;
    logic              sel_ram;
    logic              sel_cart;

    // Fields of the selected bank register
    assign page         = cur_bank[page_w-1:0];
    assign bank_ro      = cur_bank[bank_ro_bit];
    assign bank_overlay = cur_bank[bank_overlay_bit];

    // Low page bits go straight to the RAM and cartridge address pins
    assign ebus_ba = page[ba_w-1:0];

    // System RAM window at $3800-$3FFF of the quarter, overlay only
    assign sel_sysram = bank_overlay && (ebus_a[13:11] == sysram_window);

    assign sel_ram  = !ebus_mreq_n && (page >= ram_page_first);     // Pages 32-63
    assign sel_cart = !ebus_mreq_n && (page >= cart_page_first) &&
                      (page <= cart_page_last);                     // Pages 16-19

    assign ebus_ram_ce_n  = !sel_ram;
    assign ebus_cart_ce_n = !sel_cart;

    // Read-only pages still take writes inside the system RAM window
    assign ebus_ram_we_n = !(sel_ram && !ebus_wr_n && (!bank_ro || sel_sysram));

endmodule

// ==== hw/wr_strobe_sync.sv ====
`timescale 1ns/1ns

module wr_strobe_sync (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ebus_wr_n,
    input  logic [zbus_pkg::data_w-1:0] ebus_d_in,
    input  logic                        cassette_in,
    input  logic                        printer_in,
    output logic                        bus_write,      // One clk wide
    output logic [zbus_pkg::data_w-1:0] wrdata,
    output logic                        cassette_sync,
    output logic                        printer_sync
);

    import zbus_pkg::*;

    logic [sync_stages-1:0] wr_n_r;
    logic [sync_stages-1:0] cassette_r;
    logic [sync_stages-1:0] printer_r;

    ////////////////////////////////////////////////////////////
    // Write strobe
    ////////////////////////////////////////////////////////////
    // Strobe idles high, so the chain comes out of reset as ones
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_n_r <= '1;
        end else begin
            wr_n_r <= {wr_n_r[sync_stages-2:0], ebus_wr_n};
        end
    end

    // Last two stages still high/already low means a fresh falling edge
    assign bus_write = (wr_n_r[sync_stages-1 -: 2] == 2'b10);

    // Data is stable by the time the pulse fires
    always_ff @(posedge clk) begin
        if (!ebus_wr_n) begin
            wrdata <= ebus_d_in;
        end
    end

    ////////////////////////////////////////////////////////////
    // Cassette and printer inputs
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cassette_r <= '0;
            printer_r  <= '0;
        end else begin
            cassette_r <= {cassette_r[sync_stages-2:0], cassette_in};
            printer_r  <= {printer_r[sync_stages-2:0], printer_in};
        end
    end

    assign cassette_sync = cassette_r[sync_stages-1];
    assign printer_sync  = printer_r[sync_stages-1];

endmodule

// ==== hw/zbus_pkg.sv ====
package zbus_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////
    localparam int addr_w = 16;        // Z80 address bus
    localparam int data_w = 8;
    localparam int page_w = 6;         // Page field of a bank register
    localparam int ba_w   = 5;         // External bank address pins

    ////////////////////////////////////////////////////////////
    // Banking
    ////////////////////////////////////////////////////////////
    localparam int bank_count       = 4;    // One per 16 KB quarter
    localparam int bank_ro_bit      = 7;
    localparam int bank_overlay_bit = 6;

    localparam logic [page_w-1:0] cart_page_first = page_w'(16);
    localparam logic [page_w-1:0] cart_page_last  = page_w'(19);
    localparam logic [page_w-1:0] ram_page_first  = page_w'(32);   // Up to page 63

    // a[13:11] inside a quarter, $3800-$3FFF when overlay is on
    localparam logic [2:0] sysram_window = 3'b111;

    // Length of each synchroniser chain
    localparam int sync_stages = 3;

    ////////////////////////////////////////////////////////////
    // I/O ports
    ////////////////////////////////////////////////////////////
    typedef enum logic [data_w-1:0] {
        io_bank0    = 8'hF0,
        io_bank1    = 8'hF1,
        io_bank2    = 8'hF2,
        io_bank3    = 8'hF3,
        io_sysctrl  = 8'hFB,
        io_cassette = 8'hFC,
        io_cpm      = 8'hFD,    // CP/M remap on write
        io_printer  = 8'hFE,
        io_keyboard = 8'hFF
    } io_port_e;

    // Bit positions in the $FB system control port
    localparam int sysctrl_dis_regs_bit = 0;
    localparam int sysctrl_dis_psgs_bit = 1;
    localparam int sysctrl_turbo_bit    = 2;

endpackage

// ==== hw/zbus_top.sv ====
`timescale 1ns/1ns

module zbus_top (
    input  logic                        clk,
    input  logic                        reset,

    // Z80 bus
    input  logic [zbus_pkg::addr_w-1:0] ebus_a,
    input  logic [zbus_pkg::data_w-1:0] ebus_d_in,
    output logic [zbus_pkg::data_w-1:0] ebus_d_out,
    output logic                        ebus_d_oe,
    input  logic                        ebus_rd_n,
    input  logic                        ebus_wr_n,
    input  logic                        ebus_mreq_n,
    input  logic                        ebus_iorq_n,
    output logic [zbus_pkg::ba_w-1:0]   ebus_ba,
    output logic                        ebus_ram_ce_n,
    output logic                        ebus_cart_ce_n,
    output logic                        ebus_ram_we_n,

    // Keyboard matrix, 0 = pressed
    input  logic [63:0]                 keys,

    // Misc I/O
    input  logic                        cassette_in,
    output logic                        cassette_out,
    input  logic                        printer_in,
    output logic                        printer_out,
    output logic                        cpm_remap,
    output logic                        turbo_mode
);

    import zbus_pkg::*;

    logic              bus_write;
    logic [data_w-1:0] wrdata;
    logic              cassette_sync;
    logic              printer_sync;
    logic              regs_enable;
    logic [data_w-1:0] cur_bank;
    logic              bank_hit;
    logic [data_w-1:0] bank_rddata;

    wr_strobe_sync u_wr_strobe_sync (
        .clk           (clk),
        .reset         (reset),
        .ebus_wr_n     (ebus_wr_n),
        .ebus_d_in     (ebus_d_in),
        .cassette_in   (cassette_in),
        .printer_in    (printer_in),
        .bus_write     (bus_write),
        .wrdata        (wrdata),
        .cassette_sync (cassette_sync),
        .printer_sync  (printer_sync)
    );

    bank_regs u_bank_regs (
        .clk         (clk),
        .reset       (reset),
        .ebus_a      (ebus_a),
        .ebus_iorq_n (ebus_iorq_n),
        .bus_write   (bus_write),
        .wrdata      (wrdata),
        .regs_enable (regs_enable),
        .cur_bank    (cur_bank),
        .bank_hit    (bank_hit),
        .bank_rddata (bank_rddata)
    );

    mem_decode u_mem_decode (
        .ebus_a         (ebus_a),
        .ebus_mreq_n    (ebus_mreq_n),
        .ebus_wr_n      (ebus_wr_n),
        .cur_bank       (cur_bank),
        .ebus_ba        (ebus_ba),
        .ebus_ram_ce_n  (ebus_ram_ce_n),
        .ebus_cart_ce_n (ebus_cart_ce_n),
        .ebus_ram_we_n  (ebus_ram_we_n)
    );

    io_regs u_io_regs (
        .clk           (clk),
        .reset         (reset),
        .ebus_a        (ebus_a),
        .ebus_iorq_n   (ebus_iorq_n),
        .ebus_rd_n     (ebus_rd_n),
        .bus_write     (bus_write),
        .wrdata        (wrdata),
        .cassette_sync (cassette_sync),
        .printer_sync  (printer_sync),
        .keys          (keys),
        .bank_hit      (bank_hit),
        .bank_rddata   (bank_rddata),
        .regs_enable   (regs_enable),
        .cassette_out  (cassette_out),
        .printer_out   (printer_out),
        .cpm_remap     (cpm_remap),
        .turbo_mode    (turbo_mode),
        .ebus_d_out    (ebus_d_out),
        .ebus_d_oe     (ebus_d_oe)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the Z80 bus testbench with Verilator
set -e
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_zbus -f tb.f -o tb_zbus_sim

./obj_dir/tb_zbus_sim 2>&1 | tee "$log"

if grep -q "=== FAIL ===" "$log"; then
    echo "Simulation failed, see $log"
    exit 1
fi
if ! grep -q "=== PASS ===" "$log"; then
    echo "Simulation ended without a result, see $log"
    exit 1
fi
echo "Simulation passed"

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for 5 rising edges, dropped just after the last one
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== sim/tb_zbus.sv ====
`timescale 1ns/1ns

module tb_zbus;

    import zbus_pkg::*;

    logic              clk;
    logic              reset;
    logic [addr_w-1:0] ebus_a;
    logic [data_w-1:0] ebus_d_in;
    logic [data_w-1:0] ebus_d_out;
    logic              ebus_d_oe;
    logic              ebus_rd_n;
    logic              ebus_wr_n;
    logic              ebus_mreq_n;
    logic              ebus_iorq_n;
    logic [ba_w-1:0]   ebus_ba;
    logic              ebus_ram_ce_n;
    logic              ebus_cart_ce_n;
    logic              ebus_ram_we_n;
    logic [63:0]       keys;                // 0 = pressed
    logic              cassette_in;
    logic              cassette_out;
    logic              printer_in;
    logic              printer_out;
    logic              cpm_remap;
    logic              turbo_mode;

    // Reference model state
    logic [data_w-1:0] bank_m [bank_count];
    logic [2:0]        sysctrl_m;
    logic              cassette_m;
    logic              cpm_m;
    logic              printer_m;
    logic [31:0]       lfsr_state;

    // Pages at and around every class boundary
    logic [page_w-1:0] page_list [9] = '{6'd0, 6'd15, 6'd16, 6'd19, 6'd20,
                                         6'd31, 6'd32, 6'd45, 6'd63};

    tb_clock u_clock (.clk(clk), .reset(reset));

    zbus_top DUT (.*);

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        assert (actual === expected)
            else abort_run($sformatf("ERR time=%0t %s expected %0h actual %0h",
                                     $time, name, expected, actual));
    endtask

    // Nothing drives the bus unless an I/O read is in progress
    assert property (@(posedge clk) (ebus_rd_n || ebus_iorq_n) |-> !ebus_d_oe)
        else abort_run($sformatf("ERR time=%0t ebus_d_oe expected 0 actual %b",
                                 $time, ebus_d_oe));

    assert property (@(posedge clk) ebus_mreq_n |->
                     (ebus_ram_ce_n && ebus_cart_ce_n && ebus_ram_we_n))
        else abort_run($sformatf("ERR time=%0t chip enables expected 111 actual %b%b%b",
                                 $time, ebus_ram_ce_n, ebus_cart_ce_n, ebus_ram_we_n));

    initial begin
        #200_000;
        abort_run("Test sequence did not finish in time");
    end

    ////////////////////////////////////////////////////////////
    // Random bits, Galois LFSR
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[62:0], lfsr_state[0]};
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus cycles
    ////////////////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            next_cycle();
        end
    endtask

    task automatic bus_idle();
        ebus_rd_n   = 1'b1;
        ebus_wr_n   = 1'b1;
        ebus_mreq_n = 1'b1;
        ebus_iorq_n = 1'b1;
    endtask

    task automatic model_write(input logic [15:0] addr, input logic [7:0] data);
        case (addr[7:0])
            io_bank0, io_bank1, io_bank2, io_bank3:
                if (!sysctrl_m[sysctrl_dis_regs_bit]) bank_m[addr[1:0]] = data;
            io_sysctrl:  sysctrl_m  = data[2:0];
            io_cassette: cassette_m = data[0];
            io_cpm:      cpm_m      = data[0];
            io_printer:  printer_m  = data[0];
            default: ;
        endcase
    endtask

    task automatic check_outputs();
        check_value("cassette_out", {7'b0, cassette_m}, {7'b0, cassette_out});
        check_value("printer_out", {7'b0, printer_m}, {7'b0, printer_out});
        check_value("cpm_remap", {7'b0, cpm_m}, {7'b0, cpm_remap});
        check_value("turbo_mode", {7'b0, sysctrl_m[sysctrl_turbo_bit]}, {7'b0, turbo_mode});
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
        ebus_a      = addr;
        ebus_d_in   = data;
        ebus_iorq_n = 1'b0;
        ebus_wr_n   = 1'b0;
        wait_cycles(6);             // Pulse lands on the third edge
        bus_idle();
        wait_cycles(2);
        model_write(addr, data);
        check_outputs();
    endtask

    task automatic io_read(input logic [15:0] addr, output logic [7:0] data,
                           output logic oe);
        ebus_a      = addr;
        ebus_iorq_n = 1'b0;
        ebus_rd_n   = 1'b0;
        next_cycle();
        data = ebus_d_out;
        oe   = ebus_d_oe;
        bus_idle();
        next_cycle();
    endtask

    // AND of every row whose select bit is low
    function automatic logic [7:0] key_rows_and(input logic [7:0] high);
        logic [7:0] acc;
        acc = 8'hFF;
        for (int r = 0; r < 8; r++) begin
            if (!high[r]) acc = acc & keys[r*8 +: 8];
        end
        return acc;
    endfunction

    task automatic check_port(input logic [15:0] addr);
        logic [7:0] exp_data;
        logic       exp_oe;
        logic [7:0] got_data;
        logic       got_oe;
        exp_oe   = 1'b1;
        exp_data = 8'h00;
        case (addr[7:0])
            io_bank0, io_bank1, io_bank2, io_bank3: begin
                exp_oe   = !sysctrl_m[sysctrl_dis_regs_bit];
                exp_data = bank_m[addr[1:0]];
            end
            io_sysctrl:  exp_data = {5'b0, sysctrl_m};
            io_cassette: exp_data = {7'b0, !cassette_in};
            io_printer:  exp_data = {7'b0, printer_in};
            io_keyboard: exp_data = key_rows_and(addr[15:8]);
            io_cpm:      exp_data = 8'h00;
            default:     exp_oe   = 1'b0;
        endcase
        io_read(addr, got_data, got_oe);
        check_value("ebus_d_oe", {7'b0, exp_oe}, {7'b0, got_oe});
        if (exp_oe) check_value("ebus_d_out", exp_data, got_data);
    endtask

    task automatic mem_cycle(input logic [15:0] addr, input logic write);
        logic [7:0]        bank;
        logic [page_w-1:0] page;
        logic              exp_ram;
        logic              exp_cart;
        logic              exp_we;
        bank     = bank_m[addr[15:14]];
        page     = bank[page_w-1:0];
        exp_ram  = page >= ram_page_first;
        exp_cart = (page >= cart_page_first) && (page <= cart_page_last);
        exp_we   = exp_ram && write && (!bank[bank_ro_bit] ||
                   (bank[bank_overlay_bit] && addr[13:11] == sysram_window));
        ebus_a      = addr;
        ebus_mreq_n = 1'b0;
        ebus_wr_n   = !write;
        ebus_rd_n   = write;
        next_cycle();
        check_value("ebus_ba", {3'b0, page[ba_w-1:0]}, {3'b0, ebus_ba});
        check_value("ebus_ram_ce_n", {7'b0, !exp_ram}, {7'b0, ebus_ram_ce_n});
        check_value("ebus_cart_ce_n", {7'b0, !exp_cart}, {7'b0, ebus_cart_ce_n});
        check_value("ebus_ram_we_n", {7'b0, !exp_we}, {7'b0, ebus_ram_we_n});
        wait_cycles(5);
        bus_idle();
        wait_cycles(2);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [63:0] rnd;
        ebus_a      = '0;
        ebus_d_in   = '0;
        keys        = '1;
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        bus_idle();
        lfsr_state = 32'h19e8c0e2;
        sysctrl_m  = '0;
        cassette_m = 1'b0;
        cpm_m      = 1'b0;
        printer_m  = 1'b0;
        for (int i = 0; i < bank_count; i++) bank_m[i] = '0;

        next_cycle();
        for (int i = 0; i < 20 && reset; i++) begin
            next_cycle();
        end
        if (reset) abort_run("Reset was never released");

        // Reset state
        check_outputs();
        check_port(16'h0000);       // No port addressed
        check_port(16'h00FB);
        for (int i = 0; i < bank_count; i++) check_port(16'h00F0 | 16'(i));

        // Bank registers and the quarter mux
        for (int i = 0; i < bank_count; i++) begin
            rand_bits(8, rnd);
            io_write(16'h00F0 | 16'(i), rnd[7:0]);
        end
        for (int q = 0; q < bank_count; q++) begin
            check_port(16'h00F0 | 16'(q));
            rand_bits(14, rnd);
            mem_cycle({2'(q), rnd[13:0]}, 1'b0);
        end

        // Page classes with every ro/overlay combination, quarter 1
        for (int p = 0; p < 9; p++) begin
            for (int f = 0; f < 4; f++) begin
                io_write(16'h00F1, {2'(f), page_list[p]});
                mem_cycle(16'h7800, 1'b1);      // Inside the window
                mem_cycle(16'h7ABC, 1'b0);
                mem_cycle(16'h4123, 1'b1);      // Outside
                mem_cycle(16'h4123, 1'b0);
            end
        end

        // System and output ports
        for (int i = 0; i < 6; i++) begin
            rand_bits(32, rnd);
            io_write(16'h00FB, rnd[7:0]);
            check_port(16'h00FB);
            io_write(16'h00FC, rnd[15:8]);
            io_write(16'h00FD, rnd[23:16]);
            io_write(16'h00FE, rnd[31:24]);
            check_port(16'h00FD);
        end

        // dis_regs hides $F0-$F3 but not $FB
        io_write(16'h00FB, 8'h01);
        check_port(16'h00F0);
        io_write(16'h00F2, ~bank_m[2]);     // Differs from the stored value
        check_port(16'h00FB);
        io_write(16'h00FB, 8'h00);
        for (int i = 0; i < bank_count; i++) check_port(16'h00F0 | 16'(i));

        // Synchronised inputs
        for (int i = 0; i < 6; i++) begin
            rand_bits(2, rnd);
            cassette_in = rnd[0];
            printer_in  = rnd[1];
            wait_cycles(4);
            check_port(16'h00FC);
            check_port(16'h00FE);
        end

        // Keyboard matrix
        for (int i = 0; i < 16; i++) begin
            rand_bits(64, rnd);
            keys = rnd;
            check_port(16'hFFFF);       // No row selected
            rand_bits(8, rnd);
            check_port({rnd[7:0], 8'hFF});
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== tb.f ====
hw/zbus_pkg.sv
hw/wr_strobe_sync.sv
hw/bank_regs.sv
hw/mem_decode.sv
hw/io_regs.sv
hw/zbus_top.sv
sim/tb_clock.sv
sim/tb_zbus.sv
